// File: all.f
design/hqc_pkg.sv
design/fixed_weight_gen.sv
design/cyclic_mult.sv
design/encrypt_ctrl.sv
design/encrypt_top.sv
test/encrypt_checker.sv
test/tb_encrypt.sv

// File: design/cyclic_mult.sv
`timescale 1ns/1ns

module cyclic_mult (
    input  logic               clk,
    input  logic               rst,
    input  hqc_pkg::mult_cmd_t cmd,
    output hqc_pkg::mult_rsp_t rsp
);
    import hqc_pkg::*;

    poly_t             dense_r;
    poly_t             sparse_r;
    poly_t             acc;
    logic              running;
    logic              done;
    logic [STEP_W-1:0] step;

    // step 0 is folded into the load cycle, so done lands N cycles after start
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            step    <= '0;
        end else begin
            done <= 1'b0;
            if (cmd.start) begin
                running <= 1'b1;
                step    <= STEP_W'(1);
            end else if (running) begin
                step <= step + 1'b1;
                if (step == STEP_W'(N - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // dense rotates left once per step, sparse bit i reaches bit 0 at step i
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            acc      <= cmd.sparse[0] ? cmd.dense : '0;
            dense_r  <= {cmd.dense[N-2:0], cmd.dense[N-1]};
            sparse_r <= cmd.sparse >> 1;
        end else if (running) begin
            if (sparse_r[0]) begin
                acc <= acc ^ dense_r;
            end
            dense_r  <= {dense_r[N-2:0], dense_r[N-1]};
            sparse_r <= sparse_r >> 1;
        end
    end

    assign rsp.done    = done;
    assign rsp.product = acc;

endmodule

// File: design/encrypt_ctrl.sv
`timescale 1ns/1ns

module encrypt_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [hqc_pkg::K-1:0]      msg,
    input  logic [hqc_pkg::LFSR_W-1:0] theta,
    input  hqc_pkg::poly_t             h,
    input  hqc_pkg::poly_t             s,
    input  hqc_pkg::fw_rsp_t           fw_rsp,
    input  hqc_pkg::mult_rsp_t         mult_rsp,
    output logic                       fw_start,
    output logic                       fw_load,
    output logic [hqc_pkg::LFSR_W-1:0] fw_seed,
    output hqc_pkg::mult_cmd_t         mult_cmd,
    output logic                       done,
    output logic                       done_fixed_weight,
    output hqc_pkg::poly_t             u,
    output hqc_pkg::poly_t             v
);
    import hqc_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_gen_r1,
        st_gen_r2,
        st_gen_e,
        st_mul_h,
        st_mul_s,
        st_finish
    } state_t;

    state_t       state;
    logic         mult_go;
    logic [K-1:0] msg_r;
    poly_t        r1;
    poly_t        r2;
    poly_t        e;
    poly_t        codeword;

    // LFSR is seeded only by an accepted start
    assign fw_load = (state == st_idle) && start;
    // an all-zero state would lock the LFSR
    assign fw_seed = (theta == '0) ? LFSR_W'(1) : theta;

    // operand pair follows the multiply phase
    assign mult_cmd.start  = mult_go;
    assign mult_cmd.dense  = (state == st_mul_s) ? s : h;
    assign mult_cmd.sparse = r2;

    assign codeword = rep_encode(msg_r);

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= st_idle;
            fw_start          <= 1'b0;
            mult_go           <= 1'b0;
            done              <= 1'b0;
            done_fixed_weight <= 1'b0;
            u                 <= '0;
            v                 <= '0;
        end else begin
            fw_start          <= 1'b0;
            mult_go           <= 1'b0;
            done              <= 1'b0;
            done_fixed_weight <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        fw_start <= 1'b1;
                        state    <= st_gen_r1;
                    end
                end
                st_gen_r1: begin
                    if (fw_rsp.done) begin
                        fw_start <= 1'b1;
                        state    <= st_gen_r2;
                    end
                end
                st_gen_r2: begin
                    if (fw_rsp.done) begin
                        fw_start <= 1'b1;
                        state    <= st_gen_e;
                    end
                end
                st_gen_e: begin
                    // all three vectors ready, start h*r2
                    if (fw_rsp.done) begin
                        done_fixed_weight <= 1'b1;
                        mult_go           <= 1'b1;
                        state             <= st_mul_h;
                    end
                end
                st_mul_h: begin
                    if (mult_rsp.done) begin
                        u       <= r1 ^ mult_rsp.product;
                        mult_go <= 1'b1;
                        state   <= st_mul_s;
                    end
                end
                st_mul_s: begin
                    if (mult_rsp.done) begin
                        v     <= codeword ^ mult_rsp.product ^ e;
                        done  <= 1'b1;
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // operand registers
    always_ff @(posedge clk) begin
        if (fw_load) begin
            msg_r <= msg;
        end
        if (fw_rsp.done && state == st_gen_r1) begin
            r1 <= fw_rsp.vec;
        end
        if (fw_rsp.done && state == st_gen_r2) begin
            r2 <= fw_rsp.vec;
        end
        if (fw_rsp.done && state == st_gen_e) begin
            e <= fw_rsp.vec;
        end
    end

endmodule

// File: design/encrypt_top.sv
`timescale 1ns/1ns

module encrypt_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [hqc_pkg::K-1:0]      msg,
    input  logic [hqc_pkg::LFSR_W-1:0] theta,
    input  hqc_pkg::poly_t             h,
    input  hqc_pkg::poly_t             s,
    output logic                       done,
    output logic                       done_fixed_weight,
    output hqc_pkg::poly_t             u,
    output hqc_pkg::poly_t             v
);
    import hqc_pkg::*;

    // generator side
    logic              fw_start;
    logic              fw_load;
    logic [LFSR_W-1:0] fw_seed;
    fw_rsp_t           fw_rsp;

    // multiplier side
    mult_cmd_t         mult_cmd;
    mult_rsp_t         mult_rsp;

    encrypt_ctrl ctrl_i (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .msg               (msg),
        .theta             (theta),
        .h                 (h),
        .s                 (s),
        .fw_rsp            (fw_rsp),
        .mult_rsp          (mult_rsp),
        .fw_start          (fw_start),
        .fw_load           (fw_load),
        .fw_seed           (fw_seed),
        .mult_cmd          (mult_cmd),
        .done              (done),
        .done_fixed_weight (done_fixed_weight),
        .u                 (u),
        .v                 (v)
    );

    fixed_weight_gen fw_i (
        .clk   (clk),
        .rst   (rst),
        .load  (fw_load),
        .seed  (fw_seed),
        .start (fw_start),
        .rsp   (fw_rsp)
    );

    // shared by h*r2 and s*r2
    cyclic_mult mult_i (
        .clk (clk),
        .rst (rst),
        .cmd (mult_cmd),
        .rsp (mult_rsp)
    );

endmodule

// File: design/fixed_weight_gen.sv
`timescale 1ns/1ns

module fixed_weight_gen (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  logic [hqc_pkg::LFSR_W-1:0] seed,
    input  logic                       start,
    output hqc_pkg::fw_rsp_t           rsp
);
    import hqc_pkg::*;

    logic [LFSR_W-1:0] lfsr;
    logic [LFSR_W-1:0] lfsr_next;
    logic [POS_W-1:0]  cand;
    logic              accept;
    logic              running;
    logic [CNT_W-1:0]  weight_cnt;
    logic              done;
    poly_t             vec;

    // Fibonacci step, shift left and feed back into bit 0
    assign lfsr_next = {lfsr[LFSR_W-2:0], ^(lfsr & LFSR_TAPS)};
    assign cand      = lfsr_next[POS_W-1:0];

    // reject positions past the end and ones already set
    assign accept = (cand < POS_W'(N)) && !vec[cand];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr       <= LFSR_W'(1);
            running    <= 1'b0;
            weight_cnt <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;

            // state carries on from one vector to the next
            if (load) begin
                lfsr <= seed;
            end else if (running) begin
                lfsr <= lfsr_next;
            end

            if (start) begin
                running    <= 1'b1;
                weight_cnt <= '0;
            end else if (running && accept) begin
                weight_cnt <= weight_cnt + 1'b1;
                // last position placed
                if (weight_cnt == CNT_W'(WEIGHT - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // vector under construction, held after done
    always_ff @(posedge clk) begin
        if (start) begin
            vec <= '0;
        end else if (running && accept) begin
            vec[cand] <= 1'b1;
        end
    end

    assign rsp.done = done;
    assign rsp.vec  = vec;

endmodule

// File: design/hqc_pkg.sv
package hqc_pkg;

    // code dimensions
    localparam int N      = 127;
    localparam int WEIGHT = 8;
    localparam int K      = 8;
    localparam int REP    = 15;

    // position sampling from the LFSR
    localparam int                LFSR_W    = 16;
    // x^16+x^14+x^13+x^11+1, feedback from bits 15, 13, 12, 10
    localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;
    localparam int                POS_W     = 7;

    // counter widths
    localparam int CNT_W  = $clog2(WEIGHT + 1);
    localparam int STEP_W = $clog2(N);

    // bit i holds the coefficient of x^i
    typedef logic [N-1:0] poly_t;

    typedef struct packed {
        logic  start;
        poly_t dense;
        poly_t sparse;
    } mult_cmd_t;

    typedef struct packed {
        logic  done;
        poly_t product;
    } mult_rsp_t;

    typedef struct packed {
        logic  done;
        poly_t vec;
    } fw_rsp_t;

    // each message bit repeated REP times, top bits stay zero
    function automatic poly_t rep_encode(input logic [K-1:0] m);
        poly_t cw;
        cw = '0;
        for (int j = 0; j < K * REP; j++) begin
            cw[j] = m[j / REP];
        end
        return cw;
    endfunction

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the encrypt core and its testbench with Verilator, run it, check the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BINARY=sim_encrypt
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --top-module tb_encrypt -f all.f \
    --Mdir "$BUILD_DIR" -o "$BINARY"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$BINARY" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: test/encrypt_checker.sv
`timescale 1ns/1ns

module encrypt_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [hqc_pkg::K-1:0]      msg,
    input  logic [hqc_pkg::LFSR_W-1:0] theta,
    input  hqc_pkg::poly_t             h,
    input  hqc_pkg::poly_t             s,
    input  logic                       done,
    input  logic                       done_fixed_weight,
    input  hqc_pkg::poly_t             u,
    input  hqc_pkg::poly_t             v,
    output int                         pass_count,
    output int                         fail_count
);
    import hqc_pkg::*;

    int                passes = 0;
    int                fails = 0;
    int                op_num = 0;
    int                errors;
    int                dfw_pulses;
    logic              busy = 1'b0;
    logic              in_reset = 1'b0;
    logic              zero_ops;
    logic [K-1:0]      op_msg;
    logic [LFSR_W-1:0] op_theta;
    poly_t             exp_u;
    poly_t             exp_v;
    poly_t             exp_r1;
    poly_t             exp_cw;

    assign pass_count = passes;
    assign fail_count = fails;

    // x^16+x^14+x^13+x^11+1, shift left, new bit enters at 0
    function automatic logic [LFSR_W-1:0] lfsr_step(input logic [LFSR_W-1:0] st);
        return {st[LFSR_W-2:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
    endfunction

    // one vector of exact weight, state carries on to the next call
    task automatic draw_vector(inout logic [LFSR_W-1:0] st, output poly_t vec);
        int               cnt;
        logic [POS_W-1:0] pos;
        vec = '0;
        cnt = 0;
        while (cnt < WEIGHT) begin
            st = lfsr_step(st);
            pos = st[POS_W-1:0];
            if (pos < POS_W'(N) && !vec[pos]) begin
                vec[pos] = 1'b1;
                cnt++;
            end
        end
    endtask

    // product in GF(2)[x]/(x^N - 1)
    function automatic poly_t cyc_mul(input poly_t a, input poly_t b);
        poly_t prod;
        prod = '0;
        for (int i = 0; i < N; i++) begin
            if (b[i]) begin
                prod ^= (a << i) | (a >> (N - i));
            end
        end
        return prod;
    endfunction

    function automatic poly_t repeat_msg(input logic [K-1:0] m);
        poly_t cw;
        cw = '0;
        for (int i = 0; i < K; i++) begin
            for (int r = 0; r < REP; r++) begin
                cw[i * REP + r] = m[i];
            end
        end
        return cw;
    endfunction

    task automatic report(input string what);
        $display("mismatch at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string label);
        if (errors == 0) begin
            passes++;
            $display("%s: ok", label);
        end else begin
            fails++;
            $display("%s: %0d error(s)", label, errors);
        end
    endtask

    task automatic check_reset;
        errors = 0;
        if (done !== 1'b0 || done_fixed_weight !== 1'b0) begin
            report("done flags not low after reset");
        end
        if (u !== '0 || v !== '0) begin
            report($sformatf("u %h and v %h not zero after reset", u, v));
        end
        finish_test("reset state");
    endtask

    task automatic open_op;
        logic [LFSR_W-1:0] st;
        poly_t             r1;
        poly_t             r2;
        poly_t             ev;
        op_num++;
        errors = 0;
        dfw_pulses = 0;
        op_msg = msg;
        op_theta = theta;
        zero_ops = (h == '0) && (s == '0);
        // zero seed runs as one
        st = (theta == '0) ? LFSR_W'(1) : theta;
        draw_vector(st, r1);
        draw_vector(st, r2);
        draw_vector(st, ev);
        exp_r1 = r1;
        exp_cw = repeat_msg(msg);
        exp_u = r1 ^ cyc_mul(h, r2);
        exp_v = exp_cw ^ cyc_mul(s, r2) ^ ev;
    endtask

    task automatic close_op;
        if (dfw_pulses != 1) begin
            report($sformatf("done_fixed_weight pulsed %0d times before done", dfw_pulses));
        end
        if (u !== exp_u) begin
            report($sformatf("u is %h, expected %h", u, exp_u));
        end
        if (v !== exp_v) begin
            report($sformatf("v is %h, expected %h", v, exp_v));
        end
        // with h = s = 0 only the sparse vectors are left
        if (zero_ops) begin
            if ($countones(u) != WEIGHT || u !== exp_r1) begin
                report($sformatf("u has %0d set bits, expected r1 %h", $countones(u), exp_r1));
            end
            if ($countones(v ^ exp_cw) != WEIGHT) begin
                report($sformatf("v minus codeword has %0d set bits", $countones(v ^ exp_cw)));
            end
        end
        finish_test($sformatf("operation %0d (msg %h, theta %h)", op_num, op_msg, op_theta));
    endtask

    always @(posedge clk) begin
        if (rst) begin
            busy = 1'b0;
            in_reset = 1'b1;
        end else begin
            if (in_reset) begin
                check_reset();
                in_reset = 1'b0;
            end
            if (busy) begin
                if (done_fixed_weight) begin
                    dfw_pulses++;
                end
                if (done) begin
                    close_op();
                    busy = 1'b0;
                end
            end else begin
                if (done || done_fixed_weight) begin
                    $display("error at %0t ns: a done flag pulsed with no operation running",
                             $time);
                    fails++;
                end
                // starts while busy are dropped by the core
                if (start) begin
                    open_op();
                    busy = 1'b1;
                end
            end
        end
    end

endmodule

// File: test/tb_encrypt.sv
`timescale 1ns/1ns

module tb_encrypt;
    import hqc_pkg::*;

    localparam int CLK_HALF   = 20;
    localparam int TIMEOUT    = 5000;
    localparam int RANDOM_OPS = 20;

    logic              clk;
    logic              rst;
    logic              start;
    logic [K-1:0]      msg;
    logic [LFSR_W-1:0] theta;
    poly_t             h;
    poly_t             s;
    logic              done;
    logic              done_fixed_weight;
    poly_t             u;
    poly_t             v;

    integer            seed;
    int                chk_pass;
    int                chk_fail;
    int                timeouts;
    logic [K-1:0]      op_msg;
    poly_t             op_h;
    poly_t             op_s;

    encrypt_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .msg               (msg),
        .theta             (theta),
        .h                 (h),
        .s                 (s),
        .done              (done),
        .done_fixed_weight (done_fixed_weight),
        .u                 (u),
        .v                 (v)
    );

    encrypt_checker chk_i (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .msg               (msg),
        .theta             (theta),
        .h                 (h),
        .s                 (s),
        .done              (done),
        .done_fixed_weight (done_fixed_weight),
        .u                 (u),
        .v                 (v),
        .pass_count        (chk_pass),
        .fail_count        (chk_fail)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    function automatic poly_t rand_poly();
        logic [127:0] raw;
        for (int w = 0; w < 4; w++) begin
            raw[w*32 +: 32] = $random(seed);
        end
        return poly_t'(raw);
    endfunction

    // flag select: 1 for done, 0 for done_fixed_weight
    task automatic wait_flag(input bit want_done);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            seen = want_done ? done : done_fixed_weight;
            cycles++;
        end
        if (!seen) begin
            $display("timeout: %s did not pulse within %0d cycles",
                     want_done ? "done" : "done_fixed_weight", TIMEOUT);
            timeouts++;
        end
    endtask

    // second start lands mid-generation when busy_gap > 0
    task automatic run_op(input logic [K-1:0] m, input logic [LFSR_W-1:0] th,
                          input poly_t hv, input poly_t sv, input int busy_gap);
        if (timeouts == 0) begin
            @(posedge clk);
            start <= 1'b1;
            msg   <= m;
            theta <= th;
            h     <= hv;
            s     <= sv;
            @(posedge clk);
            start <= 1'b0;
            if (busy_gap > 0) begin
                repeat (busy_gap) @(posedge clk);
                start <= 1'b1;
                msg   <= ~m;
                theta <= th ^ 16'h5a5a;
                @(posedge clk);
                start <= 1'b0;
            end
            wait_flag(1'b0);
            if (timeouts == 0) begin
                wait_flag(1'b1);
            end
            // idle so that a second done would show up
            repeat (4) @(posedge clk);
        end
    endtask

    initial begin
        seed     = 23;
        timeouts = 0;
        rst   <= 1'b1;
        start <= 1'b0;
        msg   <= '0;
        theta <= '0;
        h     <= '0;
        s     <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < RANDOM_OPS; i++) begin
            op_msg = K'($random(seed));
            run_op(op_msg, LFSR_W'($random(seed)), rand_poly(), rand_poly(), 0);
        end

        // h = s = 0 exposes r1 and e directly
        for (int i = 0; i < 2; i++) begin
            op_msg = K'($random(seed));
            run_op(op_msg, LFSR_W'($random(seed)), '0, '0, 0);
        end

        // theta 0 and theta 1 must agree
        op_msg = K'($random(seed));
        op_h   = rand_poly();
        op_s   = rand_poly();
        run_op(op_msg, LFSR_W'(1), op_h, op_s, 0);
        run_op(op_msg, '0, op_h, op_s, 0);

        op_msg = K'($random(seed));
        run_op(op_msg, LFSR_W'($random(seed)), rand_poly(), rand_poly(), 6);

        $display("tests passed: %0d, tests failed: %0d, timeouts: %0d",
                 chk_pass, chk_fail, timeouts);
        if (chk_fail == 0 && timeouts == 0 && chk_pass > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
